//--- testbench/shifter_trace.txt
# T name | W reg data | R reg expected | M word_addr data | F mode base (all hex)
# mode 0 low, 1 mid, 2 mono; F checks the frame after the next vsync
T after_reset
R 00 0001
R 01 0000
R 30 0200
R 20 0007
T mono_frame
M 008000 8001
M 008001 f00f
M 008002 aaaa
M 008003 5555
F 2 008000
R 02 0001
R 03 0000
R 04 0020
T reg_readback
W 00 0001
W 01 0010
R 00 0001
R 01 0010
W 21 0fff
R 21 0777
W 22 0a5c
R 22 0254
T low_frame
W 23 0703
W 24 0070
W 2a 0505
W 2f 0161
W 30 0000
R 30 0000
M 008800 ffff
M 008801 0f0f
M 008802 00ff
M 008803 3333
F 0 008800
R 03 0010
R 04 0080
T mid_frame
W 01 0014
W 30 0100
R 30 0100
F 1 008a00
R 03 0014
R 04 0040

//--- all.f
+incdir+verilog
verilog/shifter_pkg.sv
verilog/shifter_regs.sv
verilog/shifter_timing.sv
verilog/shifter_fetch.sv
verilog/shifter_pixel.sv
verilog/shifter_top.sv
testbench/shifter_assertions.sv
testbench/shifter_tb.sv

//--- Bender.yml
package:
  name: shifter

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/shifter_pkg.sv
      - verilog/shifter_regs.sv
      - verilog/shifter_timing.sv
      - verilog/shifter_fetch.sv
      - verilog/shifter_pixel.sv
      - verilog/shifter_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/shifter_assertions.sv
      - testbench/shifter_tb.sv

//--- testbench/shifter_tb.sv
// runs testbench/shifter_trace.txt from the project root
// memory model covers 4k words from the reset base, other words read a fill pattern
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module shifter_tb;

	localparam int FRAME_CLOCKS = `SHIFTER_H_TOTAL * `SHIFTER_V_TOTAL;
	localparam int FRAME_PIXELS = `SHIFTER_H_DISP * `SHIFTER_V_DISP;
	// largest gap between two requests of one line, in clocks
	localparam int LINE_GAP = 12;
	// hsync begins this many clocks after the first display pixel of a line
	localparam int HSYNC_START = `SHIFTER_H_DISP + `SHIFTER_H_BORDER + `SHIFTER_H_BLANK;

	logic clk;
	logic reg_reset;
	shifter_pkg::reg_bus_t reg_bus;
	logic [15:0] reg_dout;
	shifter_pkg::mem_req_t mem;
	logic mem_ack;
	logic [15:0] mem_data;
	logic hs;
	logic vs;
	logic de;
	shifter_pkg::rgb_t rgb;

	// trace contents, one entry per command
	string cmd_q[$];
	string name_q[$];
	logic [31:0] arg_a_q[$];
	logic [31:0] arg_b_q[$];
	int frame_count = 0;
	logic trace_loaded = 1'b0;

	// memory model and request log
	logic [15:0] mem_words [4096];
	logic [22:0] req_addr_q[$];
	longint req_cycle_q[$];
	longint cycle = 0;
	integer seed = 63;

	// palette as written over the bus, {r, g, b}
	logic [8:0] pal_shadow [16];

	string cur_test = "";
	int test_checks = 0;
	int test_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int total_checks = 0;
	int total_errs = 0;

	shifter_top i_shifter_top (
		.clk       (clk),
		.reg_reset (reg_reset),
		.reg_bus   (reg_bus),
		.reg_dout  (reg_dout),
		.mem       (mem),
		.mem_ack   (mem_ack),
		.mem_data  (mem_data),
		.hs        (hs),
		.vs        (vs),
		.de        (de),
		.rgb       (rgb)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// ------------------------------
	// helpers
	// ------------------------------
	// every drive and sample happens 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// depends on all 23 address bits
	function automatic logic [15:0] word_fill(input logic [22:0] a);
		return a[15:0] ^ {a[6:0], a[22:14]} ^ 16'h96c3;
	endfunction

	function automatic logic [15:0] read_word(input logic [22:0] a);
		logic [22:0] ofs;
		ofs = a - `SHIFTER_BASE_RESET;
		if (a >= `SHIFTER_BASE_RESET && ofs < 23'd4096)
			return mem_words[ofs[11:0]];
		return word_fill(a);
	endfunction

	// colour of display pixel (row, x) for a frame fetched from base
	function automatic logic [8:0] expected_rgb(input int row, input int x, input int mode,
		input logic [22:0] base);
		int nw;
		int planes;
		logic [3:0] idx;
		logic [15:0] w;
		nw = (mode == 0) ? 8 : (mode == 1) ? 4 : 2;
		planes = nw / 2;
		idx = '0;
		for (int p = 0; p < planes; p++) begin
			w = read_word(base + 23'(row * nw + (x / 16) * planes + p));
			idx[p] = w[15 - (x % 16)];
		end
		// mono is white where the bit differs from palette 0 blue bit 0
		if (planes == 1)
			return (idx[0] != pal_shadow[0][0]) ? 9'h1ff : 9'h000;
		return pal_shadow[idx];
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
		test_checks++;
		assert (got === exp) else begin
			$display("[ERROR] %s: expected %0h, actual %0h", what, exp, got);
			test_errs++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%s: %s", cur_test, msg);
		test_errs++;
	endtask

	task automatic finish_test();
		if (cur_test != "") begin
			$display("test %s: %s, %0d checks, %0d errors", cur_test,
				(test_errs == 0) ? "PASS" : "FAIL", test_checks, test_errs);
			tests_run++;
			if (test_errs != 0)
				tests_failed++;
			total_checks += test_checks;
			total_errs += test_errs;
		end
	endtask

	task automatic start_test(input string name);
		finish_test();
		cur_test = name;
		test_checks = 0;
		test_errs = 0;
	endtask

	// sel, rw, uds, lds, addr, din
	task automatic reg_write(input logic [5:0] addr, input logic [15:0] data);
		reg_bus = {1'b1, 1'b0, 2'b00, addr, data};
		next_cycle();
		reg_bus = '0;
	endtask

	task automatic reg_read(input logic [5:0] addr, output logic [15:0] data);
		reg_bus = {1'b1, 1'b1, 2'b00, addr, 16'h0000};
		#1;
		data = reg_dout;
		next_cycle();
		reg_bus = '0;
	endtask

	// ------------------------------
	// frame check
	// ------------------------------
	// waits for the end of vsync, then checks the next frame's pixels and requests
	task automatic run_frame(input int mode, input logic [22:0] base);
		int cnt;
		int n;
		int nw;
		int k;
		int groups;
		int in_group;
		int hpos;
		int hline;
		logic prev_de;
		longint start_cycle;
		longint last_cycle;
		nw = (mode == 0) ? 8 : (mode == 1) ? 4 : 2;
		cnt = 0;
		while (!vs && cnt < 2 * FRAME_CLOCKS) begin
			next_cycle();
			cnt++;
		end
		while (vs && cnt < 2 * FRAME_CLOCKS) begin
			next_cycle();
			cnt++;
		end
		if (cnt >= 2 * FRAME_CLOCKS) begin
			note_failure("no end of vertical sync seen within two frames");
		end else begin
			start_cycle = cycle;
			n = 0;
			cnt = 0;
			hpos = -1;
			hline = -1;
			prev_de = 1'b0;
			// pixels come in raster order while de is high
			while (n < FRAME_PIXELS && cnt < FRAME_CLOCKS) begin
				// horizontal position counted from the first pixel of the line
				if (de && !prev_de) begin
					hpos = 0;
					hline++;
				end else if (hpos >= 0) begin
					hpos++;
				end
				if (hpos >= 0 && hpos < `SHIFTER_H_TOTAL)
					check_value($sformatf("%s hs line %0d pos %0d", cur_test, hline, hpos),
						32'(hpos >= HSYNC_START && hpos < HSYNC_START + `SHIFTER_H_SYNC), hs);
				if (de) begin
					check_value($sformatf("%s pixel row %0d col %0d", cur_test,
						n / `SHIFTER_H_DISP, n % `SHIFTER_H_DISP),
						expected_rgb(n / `SHIFTER_H_DISP, n % `SHIFTER_H_DISP, mode, base), rgb);
					n++;
				end
				prev_de = de;
				next_cycle();
				cnt++;
			end
			if (n < FRAME_PIXELS)
				note_failure($sformatf("display enable was high for only %0d pixels", n));

			// requests of this frame, grouped into lines by the idle gap
			k = 0;
			groups = 0;
			in_group = 0;
			last_cycle = start_cycle;
			for (int i = 0; i < req_addr_q.size(); i++) begin
				if (req_cycle_q[i] > start_cycle) begin
					if (k == 0 || req_cycle_q[i] - last_cycle > LINE_GAP) begin
						if (k != 0)
							check_value($sformatf("%s requests in line %0d", cur_test, groups - 1),
								nw, in_group);
						groups++;
						in_group = 0;
					end
					check_value($sformatf("%s request %0d address", cur_test, k),
						base + 23'(k), req_addr_q[i]);
					in_group++;
					k++;
					last_cycle = req_cycle_q[i];
				end
			end
			if (k != 0)
				check_value($sformatf("%s requests in line %0d", cur_test, groups - 1), nw, in_group);
			check_value($sformatf("%s lines fetched", cur_test), `SHIFTER_V_DISP, groups);
			check_value($sformatf("%s requests in frame", cur_test), `SHIFTER_V_DISP * nw, k);
		end
	endtask

	// ------------------------------
	// memory responder
	// ------------------------------
	// each phase answered after 1 or 2 clocks
	initial begin : memory_responder
		int lat;
		logic [22:0] addr;
		mem_ack = 1'b0;
		mem_data = '0;
		forever begin
			next_cycle();
			if (mem.req && !mem_ack) begin
				addr = mem.addr;
				req_addr_q.push_back(addr);
				req_cycle_q.push_back(cycle);
				lat = ($random(seed) & 1) + 1;
				repeat (lat) next_cycle();
				mem_ack = 1'b1;
				mem_data = read_word(addr);
				while (mem.req) next_cycle();
				lat = ($random(seed) & 1) + 1;
				repeat (lat) next_cycle();
				mem_ack = 1'b0;
			end
		end
	end

	// ends the run after two frame times per frame check plus margin
	initial begin : watchdog
		longint limit_ns;
		wait (trace_loaded);
		limit_ns = longint'(frame_count) * FRAME_CLOCKS * 20 * 2 + 10000;
		#(limit_ns);
		$display("watchdog expired after %0d ns, the DUT stopped making progress", limit_ns);
		$display("Simulation failed");
		$finish;
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin : main
		int fd;
		int rc;
		string tok;
		string name;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [15:0] got;
		reg_reset = 1'b1;
		reg_bus = '0;
		for (int i = 0; i < 4096; i++)
			mem_words[i] = word_fill(`SHIFTER_BASE_RESET + 23'(i));
		for (int i = 0; i < 16; i++)
			pal_shadow[i] = '0;
		pal_shadow[0] = 9'h007;

		fd = $fopen("testbench/shifter_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/shifter_trace.txt");
			total_errs++;
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok.substr(0, 0) == "#") begin
					rc = $fgets(line, fd);
				end else if (tok == "T") begin
					rc = $fscanf(fd, "%s", name);
					cmd_q.push_back(tok);
					name_q.push_back(name);
					arg_a_q.push_back('0);
					arg_b_q.push_back('0);
				end else begin
					rc = $fscanf(fd, "%h %h", a, b);
					cmd_q.push_back(tok);
					name_q.push_back("");
					arg_a_q.push_back(a);
					arg_b_q.push_back(b);
					if (tok == "F")
						frame_count++;
				end
			end
			$fclose(fd);
		end
		trace_loaded = 1'b1;

		repeat (4) @(posedge clk);
		#2;
		// outputs still in reset state
		start_test("reset_outputs");
		check_value("reset_outputs req", 0, mem.req);
		check_value("reset_outputs hs", 0, hs);
		check_value("reset_outputs vs", 0, vs);
		check_value("reset_outputs de", 0, de);
		check_value("reset_outputs rgb", 0, rgb);
		reg_reset = 1'b0;

		for (int i = 0; i < cmd_q.size(); i++) begin
			a = arg_a_q[i];
			b = arg_b_q[i];
			case (cmd_q[i])
				"T": start_test(name_q[i]);
				"W": begin
					reg_write(a[5:0], b[15:0]);
					// palette entries 20..2f keep 3 bits per channel
					if (a[5:4] == 2'b10)
						pal_shadow[a[3:0]] = {b[10:8], b[6:4], b[2:0]};
				end
				"R": begin
					reg_read(a[5:0], got);
					check_value($sformatf("%s read %0h", cur_test, a[5:0]), b, got);
				end
				"M": begin
					if (a[22:0] >= `SHIFTER_BASE_RESET && a[22:0] - `SHIFTER_BASE_RESET < 4096)
						mem_words[a[11:0]] = b[15:0];
					else
						note_failure($sformatf("preload address %0h outside the memory model", a));
				end
				"F": run_frame(int'(a), b[22:0]);
				default: note_failure($sformatf("unknown trace command %s", cmd_q[i]));
			endcase
		end
		finish_test();

		// bound protocol checks count as errors as well
		total_errs += i_shifter_top.i_shifter_assertions.fail_count;

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
			total_checks, total_errs);
		if (total_errs == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/shifter_assertions.sv
// protocol and blanking checks, bound into shifter_top
// reports only through failing assertions
`timescale 1ns/1ps
`default_nettype none

module shifter_assertions (
	input wire                        clk,
	input wire                        reg_reset,
	input wire shifter_pkg::mem_req_t mem,
	input wire                        mem_ack,
	input wire                        hs,
	input wire                        vs,
	input wire shifter_pkg::rgb_t     rgb
);

	// failed assertions so far, read at the end of the run
	int fail_count = 0;

	// ------------------------------
	// memory handshake
	// ------------------------------
	// a pending request is held until memory answers
	req_held_until_ack: assert property (@(posedge clk) disable iff (reg_reset)
		(mem.req && !mem_ack) |=> mem.req)
		else begin
			$error("req dropped before ack");
			fail_count++;
		end

	// new request only once the previous ack is gone
	no_req_rise_during_ack: assert property (@(posedge clk) disable iff (reg_reset)
		$rose(mem.req) |-> !mem_ack)
		else begin
			$error("req rose while ack was still high");
			fail_count++;
		end

	// address may only move once req is low again
	addr_stable_during_req: assert property (@(posedge clk) disable iff (reg_reset)
		mem.req |=> (!mem.req || $stable(mem.addr)))
		else begin
			$error("request address changed while req was high");
			fail_count++;
		end

	// ------------------------------
	// video output
	// ------------------------------
	black_during_sync: assert property (@(posedge clk) disable iff (reg_reset)
		(hs || vs) |-> (rgb == '0))
		else begin
			$error("rgb not black during sync");
			fail_count++;
		end

endmodule

bind shifter_top shifter_assertions i_shifter_assertions (
	.clk       (clk),
	.reg_reset (reg_reset),
	.mem       (mem),
	.mem_ack   (mem_ack),
	.hs        (hs),
	.vs        (vs),
	.rgb       (rgb)
);

`default_nettype wire

//--- verilog/shifter_top.sv
// memory answers req with ack and holds data valid while ack is high
// register accesses complete in the strobe cycle
`timescale 1ns/1ps
`default_nettype none

module shifter_top (
	input  wire                        clk,
	input  wire                        reg_reset,
	input  wire shifter_pkg::reg_bus_t reg_bus,
	output logic [15:0]                reg_dout,
	output shifter_pkg::mem_req_t      mem,
	input  wire                        mem_ack,
	input  wire [15:0]                 mem_data,
	output logic                       hs,
	output logic                       vs,
	output logic                       de,
	output shifter_pkg::rgb_t          rgb
);

	shifter_pkg::raster_t raster;
	shifter_pkg::lb_write_t lb_write;
	shifter_pkg::shift_mode_e mode;
	shifter_pkg::shift_mode_e frame_mode;
	shifter_pkg::rgb_t pal_color;
	logic [22:0] base_addr;
	logic [22:0] vaddr;
	logic [3:0] pal_index;

	// cpu registers and palette
	shifter_regs i_shifter_regs (
		.clk       (clk),
		.reg_reset (reg_reset),
		.reg_bus   (reg_bus),
		.vaddr     (vaddr),
		.pal_index (pal_index),
		.reg_dout  (reg_dout),
		.base_addr (base_addr),
		.mode      (mode),
		.pal_color (pal_color)
	);

	shifter_timing i_shifter_timing (
		.clk       (clk),
		.reg_reset (reg_reset),
		.raster    (raster)
	);

	// line prefetch into the buffer bank of the next row
	shifter_fetch i_shifter_fetch (
		.clk        (clk),
		.reg_reset  (reg_reset),
		.raster     (raster),
		.base_addr  (base_addr),
		.mode       (mode),
		.mem_ack    (mem_ack),
		.mem_data   (mem_data),
		.mem        (mem),
		.vaddr      (vaddr),
		.lb_write   (lb_write),
		.frame_mode (frame_mode)
	);

	shifter_pixel i_shifter_pixel (
		.clk        (clk),
		.reg_reset  (reg_reset),
		.raster     (raster),
		.lb_write   (lb_write),
		.frame_mode (frame_mode),
		.pal_color  (pal_color),
		.pal_index  (pal_index),
		.hs         (hs),
		.vs         (vs),
		.de         (de),
		.rgb        (rgb)
	);

endmodule

`default_nettype wire

//--- verilog/shifter_pixel.sv
// rgb, de, hs and vs trail the raster by exactly two clocks
// mono and rsvd modes use palette 0 blue bit 0 as the inversion control
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module shifter_pixel (
	input  wire                           clk,
	input  wire                           reg_reset,
	input  wire shifter_pkg::raster_t     raster,
	input  wire shifter_pkg::lb_write_t   lb_write,
	input  wire shifter_pkg::shift_mode_e frame_mode,
	input  wire shifter_pkg::rgb_t        pal_color,
	output logic [3:0]                    pal_index,
	output logic                          hs,
	output logic                          vs,
	output logic                          de,
	output shifter_pkg::rgb_t             rgb
);

	localparam shifter_pkg::rgb_t MONO_WHITE = '{r: 3'd7, g: 3'd7, b: 3'd7};

	// two banks, one filling while the other is shown
	logic [15:0] lb_mem [2][`SHIFTER_LB_WORDS];

	logic [3:0][15:0] group_words;
	logic [3:0][15:0] plane_sr;
	logic [3:0] pix_idx;
	logic mono;
	logic load;

	// first pipeline stage control
	logic p1_blank;
	logic p1_de;
	logic p1_hs;
	logic p1_vs;

	// word of plane p in the current 16-pixel group
	function automatic logic [2:0] plane_word(
		input shifter_pkg::shift_mode_e m,
		input logic grp,
		input logic [1:0] p
	);
		case (m)
			shifter_pkg::LOW: return {grp, p};
			shifter_pkg::MID: return {1'b0, grp, p[0]};
			default:          return {2'b00, grp};
		endcase
	endfunction

	function automatic logic plane_used(input shifter_pkg::shift_mode_e m, input logic [1:0] p);
		case (m)
			shifter_pkg::LOW: return 1'b1;
			shifter_pkg::MID: return !p[1];
			default:          return (p == 2'd0);
		endcase
	endfunction

	function automatic logic blanked(input shifter_pkg::raster_state_e s);
		return (s == shifter_pkg::SYNC) || (s == shifter_pkg::BLANK);
	endfunction

	always_ff @(posedge clk) begin
		if (lb_write.we)
			lb_mem[lb_write.bank][lb_write.word] <= lb_write.data;
	end

	// ------------------------------
	// stage 1 buffer read and shift
	// ------------------------------
	// rsvd decodes like mono
	assign mono = frame_mode[1];
	// reload at the start of every group
	assign load = raster.de && (raster.disp_x[3:0] == 4'd0);

	always_comb begin
		for (int p = 0; p < 4; p++) begin
			if (plane_used(frame_mode, 2'(p)))
				group_words[p] =
					lb_mem[raster.line_odd][plane_word(frame_mode, raster.disp_x[4], 2'(p))];
			else
				group_words[p] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			plane_sr <= group_words;
		end else begin
			for (int p = 0; p < 4; p++) begin
				plane_sr[p] <= {plane_sr[p][14:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reg_reset) begin
			p1_blank <= 1'b1;
			p1_de <= 1'b0;
			p1_hs <= 1'b0;
			p1_vs <= 1'b0;
		end else begin
			p1_blank <= blanked(raster.h_state) || blanked(raster.v_state);
			p1_de <= raster.de;
			p1_hs <= raster.hs;
			p1_vs <= raster.vs;
		end
	end

	// msb first, plane 0 is the index lsb
	assign pix_idx = {plane_sr[3][15], plane_sr[2][15], plane_sr[1][15], plane_sr[0][15]};
	// border and mono look up entry 0
	assign pal_index = (p1_de && !mono) ? pix_idx : 4'd0;

	// ------------------------------
	// stage 2 output register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			hs <= 1'b0;
			vs <= 1'b0;
			de <= 1'b0;
			rgb <= '0;
		end else begin
			hs <= p1_hs;
			vs <= p1_vs;
			de <= p1_de;
			if (p1_blank)
				rgb <= '0;
			else if (p1_de && mono)
				// white where the bit differs from the inversion bit
				rgb <= (plane_sr[0][15] != pal_color.b[0]) ? MONO_WHITE : '0;
			else
				rgb <= pal_color;
		end
	end

endmodule

`default_nettype wire

//--- verilog/shifter_fetch.sv
// one word per four-phase handshake, a full line must finish within 64 clocks
// mode and base are taken once per frame at frame_start
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module shifter_fetch (
	input  wire                           clk,
	input  wire                           reg_reset,
	input  wire shifter_pkg::raster_t     raster,
	input  wire [22:0]                    base_addr,
	input  wire shifter_pkg::shift_mode_e mode,
	input  wire                           mem_ack,
	input  wire [15:0]                    mem_data,
	output shifter_pkg::mem_req_t         mem,
	output logic [22:0]                   vaddr,
	output shifter_pkg::lb_write_t        lb_write,
	output shifter_pkg::shift_mode_e      frame_mode
);

	shifter_pkg::fetch_state_e state;
	// words captured in the current line
	logic [3:0] wcnt;
	logic [3:0] nwords;

	// line buffer write port
	logic        lb_we;
	logic        lb_bank;
	logic [2:0]  lb_word;
	logic [15:0] lb_data;

	// words per line, 16 pixels per word and plane
	always_comb begin
		case (frame_mode)
			shifter_pkg::LOW: nwords = 4'd8;
			shifter_pkg::MID: nwords = 4'd4;
			default:          nwords = 4'd2;
		endcase
	end

	// address held by vaddr for the whole request phase
	assign mem = '{req: (state == shifter_pkg::FETCH_REQ), addr: vaddr};
	assign lb_write = '{we: lb_we, bank: lb_bank, word: lb_word, data: lb_data};

	// ------------------------------
	// request FSM and address counter
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			state <= shifter_pkg::FETCH_IDLE;
			wcnt <= '0;
			vaddr <= `SHIFTER_BASE_RESET;
			frame_mode <= shifter_pkg::MONO;
			lb_we <= 1'b0;
		end else begin
			lb_we <= 1'b0;

			// frame reload, never during a fetch
			if (raster.frame_start) begin
				vaddr <= base_addr;
				frame_mode <= mode;
			end

			case (state)
				shifter_pkg::FETCH_IDLE: begin
					// prefetch the next display row
					if (raster.line_start && raster.fetch_line) begin
						wcnt <= '0;
						state <= shifter_pkg::FETCH_REQ;
					end
				end
				shifter_pkg::FETCH_REQ: begin
					// capture on first ack and drop req on the same edge
					if (mem_ack) begin
						lb_we <= 1'b1;
						vaddr <= vaddr + 23'd1;
						wcnt <= wcnt + 4'd1;
						state <= shifter_pkg::FETCH_RELEASE;
					end
				end
				shifter_pkg::FETCH_RELEASE: begin
					// next request only after ack is seen low
					if (!mem_ack) begin
						if (wcnt == nwords)
							state <= shifter_pkg::FETCH_IDLE;
						else
							state <= shifter_pkg::FETCH_REQ;
					end
				end
				default: state <= shifter_pkg::FETCH_IDLE;
			endcase
		end
	end

	// write data and position, plane 0 first within each group
	// bank is the one the next line reads
	always_ff @(posedge clk) begin
		if ((state == shifter_pkg::FETCH_REQ) && mem_ack) begin
			lb_bank <= ~raster.line_odd;
			lb_word <= wcnt[2:0];
			lb_data <= mem_data;
		end
	end

endmodule

`default_nettype wire

//--- verilog/shifter_timing.sv
// line 0 is the last top border line, display rows are lines 1 to 8
// so frame_start coincides with the fetch of the first display row
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module shifter_timing (
	input  wire                 clk,
	input  wire                 reg_reset,
	output shifter_pkg::raster_t raster
);

	logic [5:0] hcnt;
	logic [3:0] vcnt;
	// line position counted from the first display row
	logic [3:0] vpos;
	shifter_pkg::raster_state_e h_state;
	shifter_pkg::raster_state_e v_state;

	// phase order display, border, blank, sync, blank, border
	// one decoder for both axes
	function automatic shifter_pkg::raster_state_e phase_of(
		input int pos,
		input int disp,
		input int border,
		input int blank,
		input int sync
	);
		if (pos < disp)
			return shifter_pkg::DISP;
		if (pos < disp + border)
			return shifter_pkg::BORDER;
		if (pos < disp + border + blank)
			return shifter_pkg::BLANK;
		if (pos < disp + border + blank + sync)
			return shifter_pkg::SYNC;
		if (pos < disp + border + 2 * blank + sync)
			return shifter_pkg::BLANK;
		return shifter_pkg::BORDER;
	endfunction

	// wraps 0 to 15 so line 0 lands on the last border line
	assign vpos = vcnt - 4'd1;

	assign h_state = phase_of(int'(hcnt), `SHIFTER_H_DISP, `SHIFTER_H_BORDER,
		`SHIFTER_H_BLANK, `SHIFTER_H_SYNC);
	assign v_state = phase_of(int'(vpos), `SHIFTER_V_DISP, `SHIFTER_V_BORDER,
		`SHIFTER_V_BLANK, `SHIFTER_V_SYNC);

	// ------------------------------
	// counters
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == 6'(`SHIFTER_H_TOTAL - 1)) begin
			hcnt <= '0;
			// line end
			if (vcnt == 4'(`SHIFTER_V_TOTAL - 1))
				vcnt <= '0;
			else
				vcnt <= vcnt + 4'd1;
		end else begin
			hcnt <= hcnt + 6'd1;
		end
	end

	// registered raster outputs, one clock behind the counters
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			raster <= '0;
		end else begin
			raster.line_start <= (hcnt == '0);
			raster.frame_start <= (hcnt == '0) && (vcnt == '0);
			// lines 0 to 7 prefetch display rows 1 to 8
			raster.fetch_line <= (vcnt < 4'(`SHIFTER_V_DISP));
			raster.disp_x <= hcnt[4:0];
			raster.line_odd <= vcnt[0];
			raster.h_state <= h_state;
			raster.v_state <= v_state;
			raster.hs <= (h_state == shifter_pkg::SYNC);
			raster.vs <= (v_state == shifter_pkg::SYNC);
			raster.de <= (h_state == shifter_pkg::DISP) && (v_state == shifter_pkg::DISP);
		end
	end

endmodule

`default_nettype wire

//--- verilog/shifter_regs.sv
// accepts register accesses in a single strobe cycle without wait states
// st palette only, 3 bits per channel, no low base byte
`timescale 1ns/1ps
`default_nettype none

`include "shifter_defines.svh"

module shifter_regs (
	input  wire                        clk,
	input  wire                        reg_reset,
	input  wire shifter_pkg::reg_bus_t reg_bus,
	input  wire [22:0]                 vaddr,
	input  wire [3:0]                  pal_index,
	output logic [15:0]                reg_dout,
	output logic [22:0]                base_addr,
	output shifter_pkg::shift_mode_e   mode,
	output shifter_pkg::rgb_t          pal_color
);

	// sixteen colour entries
	shifter_pkg::rgb_t palette [16];

	logic wr;
	logic pal_sel;
	shifter_pkg::rgb_t pal_rd;

	// write strobe, byte lanes checked per field
	assign wr = reg_bus.sel && !reg_bus.rw;

	// palette occupies 20..2f
	assign pal_sel = (reg_bus.addr & 6'h30) == `SHIFTER_REG_PALETTE;
	assign pal_rd = palette[reg_bus.addr[3:0]];

	// pixel side lookup
	assign pal_color = palette[pal_index];

	// ------------------------------
	// register writes
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reg_reset) begin
			base_addr <= `SHIFTER_BASE_RESET;
			mode <= shifter_pkg::MONO;
			for (int i = 0; i < 16; i++) begin
				palette[i] <= '0;
			end
			// blue 7 on entry 0, mono shows dark pixels on set bits
			palette[0].b <= 3'd7;
		end else if (wr) begin
			if (!reg_bus.lds) begin
				// hi or mid write also clears the low address bits
				if (reg_bus.addr == `SHIFTER_REG_BASE_HI) begin
					base_addr[22:15] <= reg_bus.din[7:0];
					base_addr[6:0] <= '0;
				end
				if (reg_bus.addr == `SHIFTER_REG_BASE_MID) begin
					base_addr[14:7] <= reg_bus.din[7:0];
					base_addr[6:0] <= '0;
				end
			end

			// mode sits in the upper byte
			if ((reg_bus.addr == `SHIFTER_REG_MODE) && !reg_bus.uds) begin
				mode <= shifter_pkg::shift_mode_e'(reg_bus.din[9:8]);
			end

			if (pal_sel) begin
				// red in the upper lane
				if (!reg_bus.uds) begin
					palette[reg_bus.addr[3:0]].r <= reg_bus.din[10:8];
				end
				// green and blue in the lower lane
				if (!reg_bus.lds) begin
					palette[reg_bus.addr[3:0]].g <= reg_bus.din[6:4];
					palette[reg_bus.addr[3:0]].b <= reg_bus.din[2:0];
				end
			end
		end
	end

	// ------------------------------
	// register reads
	// ------------------------------
	// combinational while sel and rw are high, unused bits read zero
	always_comb begin
		reg_dout = '0;
		if (reg_bus.sel && reg_bus.rw) begin
			if (pal_sel) begin
				reg_dout = {5'h00, pal_rd.r, 1'b0, pal_rd.g, 1'b0, pal_rd.b};
			end else begin
				case (reg_bus.addr)
					`SHIFTER_REG_BASE_HI:   reg_dout = {8'h00, base_addr[22:15]};
					`SHIFTER_REG_BASE_MID:  reg_dout = {8'h00, base_addr[14:7]};
					// live video address counter
					`SHIFTER_REG_VADDR_HI:  reg_dout = {8'h00, vaddr[22:15]};
					`SHIFTER_REG_VADDR_MID: reg_dout = {8'h00, vaddr[14:7]};
					// byte address, so the word lsb shifts up one
					`SHIFTER_REG_VADDR_LO:  reg_dout = {8'h00, vaddr[6:0], 1'b0};
					`SHIFTER_REG_MODE:      reg_dout = {6'h00, mode, 8'h00};
					default:                reg_dout = '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/shifter_pkg.sv
// types shared by the shifter blocks
// field widths follow the fixed geometry of the defines header
`default_nettype none

package shifter_pkg;

	// shift mode register encoding, rsvd shows as mono
	typedef enum logic [1:0] {
		LOW  = 2'd0,
		MID  = 2'd1,
		MONO = 2'd2,
		RSVD = 2'd3
	} shift_mode_e;

	// raster phase per axis
	typedef enum logic [1:0] {
		SYNC   = 2'd0,
		BLANK  = 2'd1,
		BORDER = 2'd2,
		DISP   = 2'd3
	} raster_state_e;

	// four-phase memory reader
	typedef enum logic [1:0] {
		FETCH_IDLE    = 2'd0,
		FETCH_REQ     = 2'd1,
		FETCH_RELEASE = 2'd2
	} fetch_state_e;

	// cpu register strobe, byte lanes active low
	typedef struct packed {
		logic        sel;
		logic        rw;
		logic        uds;
		logic        lds;
		logic [5:0]  addr;
		logic [15:0] din;
	} reg_bus_t;

	typedef struct packed {
		logic        req;
		logic [22:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} rgb_t;

	// registered timing outputs
	typedef struct packed {
		logic          line_start;
		logic          frame_start;
		logic          fetch_line;
		logic [4:0]    disp_x;
		logic          line_odd;
		raster_state_e h_state;
		raster_state_e v_state;
		logic          hs;
		logic          vs;
		logic          de;
	} raster_t;

	typedef struct packed {
		logic        we;
		logic        bank;
		logic [2:0]  word;
		logic [15:0] data;
	} lb_write_t;

endpackage

`default_nettype wire

//--- verilog/shifter_defines.svh
// fixed raster geometry, the RTL only works with these values
// the counters assume a 64 clock line and a 16 line frame
`ifndef SHIFTER_DEFINES_SVH
`define SHIFTER_DEFINES_SVH

// ------------------------------
// horizontal phases in clocks
// ------------------------------
// display starts at horizontal count 0
`define SHIFTER_H_DISP    32
`define SHIFTER_H_BORDER  8
`define SHIFTER_H_BLANK   4
`define SHIFTER_H_SYNC    8
`define SHIFTER_H_TOTAL   (`SHIFTER_H_DISP + 2 * (`SHIFTER_H_BORDER + `SHIFTER_H_BLANK) + \
	`SHIFTER_H_SYNC)

// ------------------------------
// vertical phases in lines
// ------------------------------
`define SHIFTER_V_DISP    8
`define SHIFTER_V_BORDER  2
`define SHIFTER_V_BLANK   1
`define SHIFTER_V_SYNC    2
`define SHIFTER_V_TOTAL   (`SHIFTER_V_DISP + 2 * (`SHIFTER_V_BORDER + `SHIFTER_V_BLANK) + \
	`SHIFTER_V_SYNC)

// video base after reset, word address
`define SHIFTER_BASE_RESET     23'h8000

// cpu register word addresses
`define SHIFTER_REG_BASE_HI    6'h00
`define SHIFTER_REG_BASE_MID   6'h01
`define SHIFTER_REG_VADDR_HI   6'h02
`define SHIFTER_REG_VADDR_MID  6'h03
`define SHIFTER_REG_VADDR_LO   6'h04
// sixteen entries at 20 through 2f
`define SHIFTER_REG_PALETTE    6'h20
`define SHIFTER_REG_MODE       6'h30

// words per line buffer bank, enough for one low-res line
`define SHIFTER_LB_WORDS       8

`endif
